// File: source/riotPkg.sv
package riotPkg;

   // Widths fixed by the original part
   typedef logic [7:0] byteT;      // Data byte on bus, ports and timer
   typedef logic [6:0] ramAddrT;   // RAM index, also the bus address
   typedef logic [9:0] prescaleT;  // Prescaler count

   localparam int ramDepth = 128;

   // Prescaler reload values for divide by 1, 8, 64, 1024
   localparam prescaleT dividerTable [4] = '{10'd0, 10'd7, 10'd63, 10'd1023};

   // Port B power-up value, data and direction alike
   localparam byteT drbResetValue = 8'h14;

   // Decoded access of one bus cycle
   typedef enum logic [3:0] {
      opNop,
      opReadRam,
      opWriteRam,
      opReadDra,
      opWriteDra,
      opReadDdra,
      opWriteDdra,
      opReadDrb,
      opWriteDrb,
      opReadDdrb,
      opWriteDdrb,
      opReadTimer,
      opWriteTimer,
      opReadFlags,
      opWriteEdgeCtl
   } riotOpE;

   typedef struct packed {
      riotOpE  op;     // opNop when chip not selected
      ramAddrT addr;   // Raw address, units pick their own bits
      byteT    wdata;  // Write data
   } busOpT;

   // Interrupt state toward the bus interface
   typedef struct packed {
      logic timerFlag;
      logic timerEnable;
      logic pa7Flag;
      logic pa7Enable;
   } irqStatusT;

endpackage

// File: source/riotBusInterface.sv
`timescale 1ns/1ps

module riotBusInterface import riotPkg::*; (
   input  logic      CLK,
   input  logic      rstN,
   input  logic      cs,
   input  logic      csN,
   input  logic      rsN,
   input  logic      rwN,
   input  ramAddrT   addr,
   input  byteT      din,
   output busOpT     busOp,
   input  byteT      ramData,
   input  byteT      paRead,
   input  byteT      pbRead,
   input  byteT      ddra,
   input  byteT      ddrb,
   input  byteT      timerValue,
   input  irqStatusT irqStatus,
   output byteT      dout,
   output logic      irqN
);

   logic chipSel;  // Both selects asserted
   logic readHit;  // Current op returns data
   byteT readData; // Read mux output

   assign chipSel = cs & ~csN;

   // Strobe decode
   always_comb begin
      busOp.addr  = addr;
      busOp.wdata = din;
      if (!chipSel) begin
         busOp.op = opNop;
      end else if (!rsN) begin
         busOp.op = rwN ? opReadRam : opWriteRam;  // RAM select
      end else if (!addr[2]) begin
         // Port register file
         case (addr[1:0])
            2'd0:    busOp.op = rwN ? opReadDra  : opWriteDra;
            2'd1:    busOp.op = rwN ? opReadDdra : opWriteDdra;
            2'd2:    busOp.op = rwN ? opReadDrb  : opWriteDrb;
            default: busOp.op = rwN ? opReadDdrb : opWriteDdrb;
         endcase
      end else if (rwN) begin
         busOp.op = addr[0] ? opReadFlags : opReadTimer;
      end else begin
         busOp.op = addr[4] ? opWriteTimer : opWriteEdgeCtl;  // addr[4] low is edge control
      end
   end

   // Read data mux, values from before the edge
   always_comb begin
      readHit  = 1'b1;
      readData = '0;
      case (busOp.op)
         opReadRam:   readData = ramData;
         opReadDra:   readData = paRead;
         opReadDdra:  readData = ddra;
         opReadDrb:   readData = pbRead;
         opReadDdrb:  readData = ddrb;
         opReadTimer: readData = timerValue;
         opReadFlags: readData = {irqStatus.timerFlag, irqStatus.pa7Flag, 6'b0};
         default:     readHit  = 1'b0;  // Writes and idle cycles
      endcase
   end

   // dout holds until the next read
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         dout <= '0;
      end else if (readHit) begin
         dout <= readData;
      end
   end

   // Active low, either source
   assign irqN = ~((irqStatus.timerFlag & irqStatus.timerEnable) |
                   (irqStatus.pa7Flag & irqStatus.pa7Enable));

endmodule

// File: source/riotRam.sv
`timescale 1ns/1ps

module riotRam import riotPkg::*; (
   input  logic  CLK,
   input  busOpT busOp,
   output byteT  ramData
);

   // Scratch RAM, contents undefined at power-up
   byteT mem [ramDepth];

   always_ff @(posedge CLK) begin
      if (busOp.op == opWriteRam) begin
         mem[busOp.addr] <= busOp.wdata;
      end
   end

   // Combinational read, registered later in the bus interface
   assign ramData = mem[busOp.addr];

endmodule

// File: source/riotPorts.sv
`timescale 1ns/1ps

module riotPorts import riotPkg::*; (
   input  logic  CLK,
   input  logic  rstN,
   input  busOpT busOp,
   input  byteT  paIn,
   input  byteT  pbIn,
   output byteT  paOut,
   output byteT  pbOut,
   output byteT  paRead,
   output byteT  pbRead,
   output byteT  ddra,
   output byteT  ddrb,
   output logic  pa7Flag,
   output logic  pa7Enable
);

   byteT dra;       // Port A data register
   byteT drb;       // Port B data register
   logic edgeMode;  // 1 = rising edge
   logic pa7;       // Effective PA7
   logic pa7Prev;   // PA7 one cycle ago
   logic pa7Edge;

   // Output bits only where the direction register is set
   assign paOut = dra & ddra;
   assign pbOut = drb & ddrb;

   // Input pins on input bits, register on output bits
   assign paRead = (paIn & ~ddra) | (dra & ddra);
   assign pbRead = (pbIn & ~ddrb) | (drb & ddrb);

   assign pa7     = ddra[7] ? dra[7] : paIn[7];
   assign pa7Edge = (pa7 != pa7Prev) && (pa7 == edgeMode);  // Selected edge only

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         dra       <= '0;
         ddra      <= '0;
         drb       <= drbResetValue;
         ddrb      <= drbResetValue;
         edgeMode  <= 1'b0;
         pa7Enable <= 1'b0;
         pa7Flag   <= 1'b0;
         pa7Prev   <= 1'b0;
      end else begin
         pa7Prev <= pa7;  // Sampled every cycle, selected or not
         case (busOp.op)
            opWriteDra:  dra  <= busOp.wdata;
            opWriteDdra: ddra <= busOp.wdata;
            opWriteDrb:  drb  <= busOp.wdata;
            opWriteDdrb: ddrb <= busOp.wdata;
            opWriteEdgeCtl: begin
               edgeMode  <= busOp.addr[0];
               pa7Enable <= busOp.addr[1];
            end
            default: ;
         endcase
         // Flag read beats a simultaneous edge
         if (busOp.op == opReadFlags) begin
            pa7Flag <= 1'b0;
         end else if (pa7Edge) begin
            pa7Flag <= 1'b1;
         end
      end
   end

endmodule

// File: source/riotTimer.sv
`timescale 1ns/1ps

module riotTimer import riotPkg::*; (
   input  logic  CLK,
   input  logic  rstN,
   input  busOpT busOp,
   output byteT  timerValue,
   output logic  timerFlag,
   output logic  timerEnable
);

   byteT       counter;    // Interval counter
   prescaleT   prescaler;  // Counts down to the next counter step
   logic [1:0] divSel;     // Active divider index
   logic       expire;     // Counter steps past zero this edge
   logic       timerAccess;

   assign timerValue  = counter;  // Pre-edge value for reads
   assign expire      = (prescaler == '0) && (counter == '0);
   assign timerAccess = (busOp.op == opReadTimer) || (busOp.op == opWriteTimer);

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         counter     <= '0;
         prescaler   <= '0;
         divSel      <= '0;
         timerEnable <= 1'b0;
      end else if (busOp.op == opWriteTimer) begin
         // Load count, divider and enable
         counter     <= busOp.wdata;
         divSel      <= busOp.addr[1:0];
         prescaler   <= dividerTable[busOp.addr[1:0]];
         timerEnable <= busOp.addr[3];
      end else if (prescaler != '0) begin
         prescaler <= prescaler - 10'd1;
      end else begin
         counter <= counter - 8'd1;  // Wraps 0 to FF
         if (counter == '0) begin
            // After expiry count every cycle
            divSel    <= 2'd0;
            prescaler <= dividerTable[0];
         end else begin
            prescaler <= dividerTable[divSel];
         end
      end
   end

   // Expiry flag, cleared by any timer access
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         timerFlag <= 1'b0;
      end else if (timerAccess) begin
         timerFlag <= 1'b0;  // Access wins over expiry
      end else if (expire) begin
         timerFlag <= 1'b1;
      end
   end

endmodule

// File: source/riotTop.sv
`timescale 1ns/1ps

module riotTop import riotPkg::*; (
   input  logic    CLK,
   input  logic    rstN,
   input  logic    cs,
   input  logic    csN,
   input  logic    rsN,
   input  logic    rwN,
   input  ramAddrT addr,
   input  byteT    din,
   output byteT    dout,
   output logic    irqN,
   input  byteT    paIn,
   input  byteT    pbIn,
   output byteT    paOut,
   output byteT    pbOut
);

   busOpT     busOp;      // Decoded access, shared by all units
   byteT      ramData;
   byteT      paRead;
   byteT      pbRead;
   byteT      ddra;
   byteT      ddrb;
   byteT      timerValue;
   irqStatusT irqStatus;  // Filled field by field from the units

   riotBusInterface busInterface (
      .CLK(CLK), .rstN(rstN),
      .cs(cs), .csN(csN), .rsN(rsN), .rwN(rwN),
      .addr(addr), .din(din),
      .busOp(busOp),
      .ramData(ramData), .paRead(paRead), .pbRead(pbRead),
      .ddra(ddra), .ddrb(ddrb), .timerValue(timerValue),
      .irqStatus(irqStatus),
      .dout(dout), .irqN(irqN)
   );

   riotRam ram (.CLK(CLK), .busOp(busOp), .ramData(ramData));

   riotPorts ports (
      .CLK(CLK), .rstN(rstN), .busOp(busOp),
      .paIn(paIn), .pbIn(pbIn),
      .paOut(paOut), .pbOut(pbOut),
      .paRead(paRead), .pbRead(pbRead),
      .ddra(ddra), .ddrb(ddrb),
      .pa7Flag(irqStatus.pa7Flag), .pa7Enable(irqStatus.pa7Enable)
   );

   riotTimer timer (
      .CLK(CLK), .rstN(rstN), .busOp(busOp),
      .timerValue(timerValue),
      .timerFlag(irqStatus.timerFlag), .timerEnable(irqStatus.timerEnable)
   );

endmodule

// File: dv/riotAssertions.sv
`timescale 1ns/1ps

module riotAssertions import riotPkg::*; (
   input logic CLK,
   input logic rstN,
   input logic cs,
   input logic csN,
   input logic rwN,
   input byteT dout,
   input logic irqN,
   input byteT pbOut
);

   int   failCount = 0;  // Polled by the testbench at the end
   logic readCycle;      // Any selected read

   assign readCycle = cs & ~csN & rwN;

   knownOutputs: assert property (@(posedge CLK) disable iff (!rstN)
      !$isunknown({irqN, dout}))
      else begin
         $error("irqN or dout unknown after reset");
         failCount++;
      end

   // dout only moves at the edge that ends a read
   doutHolds: assert property (@(posedge CLK) disable iff (!rstN)
      !$past(readCycle) |-> $stable(dout))
      else begin
         $error("dout changed without a read");
         failCount++;
      end

   pbResetValue: assert property (@(posedge CLK) $rose(rstN) |-> pbOut == 8'h14)
      else begin
         $error("pbOut not at its reset value after reset release");
         failCount++;
      end

endmodule

// File: dv/riotTb.sv
`timescale 1ns/1ps

module riotTb import riotPkg::*; ();

   // Reset 16 + RAM 400 + ports 150 + timer count ~3600 + irq tests ~300 plus margin
   localparam int maxCycles = 20000;

   logic    CLK = 1'b0;
   logic    rstN;
   logic    cs;
   logic    csN;
   logic    rsN;
   logic    rwN;
   ramAddrT addr;
   byteT    din;
   byteT    paIn;
   byteT    pbIn;
   byteT    dout;
   logic    irqN;
   byteT    paOut;
   byteT    pbOut;

   // Reference model state
   byteT       mRam [ramDepth];
   byteT       mDra;
   byteT       mDdra;
   byteT       mDrb;
   byteT       mDdrb;
   logic       mEdgeMode;
   logic       mPa7En;
   logic       mPa7Flag;
   logic       mPa7Prev;
   byteT       mCounter;
   int         mPrescale;
   logic [1:0] mDivSel;
   logic       mTimerEn;
   logic       mTimerFlag;
   byteT       mDout;        // Expected dout

   logic [31:0] rngState = 32'h688b7c30;
   int          cycleCount = 0;
   int          checks = 0;
   int          errors = 0;
   int          testsRun = 0;
   int          testsFailed = 0;
   int          errorsAtStart;
   string       testName;

   riotTop UUT (
      .CLK(CLK), .rstN(rstN),
      .cs(cs), .csN(csN), .rsN(rsN), .rwN(rwN),
      .addr(addr), .din(din),
      .dout(dout), .irqN(irqN),
      .paIn(paIn), .pbIn(pbIn),
      .paOut(paOut), .pbOut(pbOut)
   );

   bind riotTop riotAssertions boundChecks (
      .CLK(CLK), .rstN(rstN), .cs(cs), .csN(csN), .rwN(rwN),
      .dout(dout), .irqN(irqN), .pbOut(pbOut)
   );

   always #50 CLK = ~CLK;  // 100 ns period

   // Run limit
   always @(posedge CLK) begin
      cycleCount++;
      if (cycleCount >= maxCycles) begin
         $display("timeout: run did not finish within %0d cycles", maxCycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] nextRand();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return {8'd0, rngState[31:8]};  // Upper bits since low ones repeat fast
   endfunction

   // Prescaler reload per divider select
   function automatic int divReload(input logic [1:0] sel);
      case (sel)
         2'd0:    return 0;
         2'd1:    return 7;
         2'd2:    return 63;
         default: return 1023;
      endcase
   endfunction

   // Register bit where the direction bit is set, pin bit elsewhere
   function automatic byteT mixPins(input byteT pins, input byteT dr, input byteT ddr);
      byteT mixed;
      for (int i = 0; i < 8; i++) begin
         mixed[i] = ddr[i] ? dr[i] : pins[i];
      end
      return mixed;
   endfunction

   function automatic logic expIrqN();
      return !((mTimerFlag && mTimerEn) || (mPa7Flag && mPa7En));
   endfunction

   task automatic modelReset();
      mDra       = 8'h00;
      mDdra      = 8'h00;
      mDrb       = 8'h14;
      mDdrb      = 8'h14;
      mEdgeMode  = 1'b0;
      mPa7En     = 1'b0;
      mPa7Flag   = 1'b0;
      mPa7Prev   = 1'b0;
      mCounter   = 8'h00;
      mPrescale  = 0;
      mDivSel    = 2'd0;
      mTimerEn   = 1'b0;
      mTimerFlag = 1'b0;
      mDout      = 8'h00;
   endtask

   // One clock edge of the chip with all decisions on pre-edge state
   task automatic modelStep();
      logic sel;
      logic timerRead;
      logic timerWrite;
      logic flagRead;
      logic pa7Now;
      logic edgeSeen;
      logic expireNow;
      sel        = cs && !csN;
      timerRead  = sel && rsN && addr[2] && rwN && !addr[0];
      timerWrite = sel && rsN && addr[2] && !rwN && addr[4];
      flagRead   = sel && rsN && addr[2] && rwN && addr[0];
      pa7Now     = mDdra[7] ? mDra[7] : paIn[7];
      edgeSeen   = (pa7Now != mPa7Prev) && (pa7Now == mEdgeMode);
      expireNow  = (mPrescale == 0) && (mCounter == 8'h00);
      if (sel && rwN) begin
         if (!rsN) begin
            mDout = mRam[addr];
         end else if (!addr[2]) begin
            case (addr[1:0])
               2'd0:    mDout = mixPins(paIn, mDra, mDdra);
               2'd1:    mDout = mDdra;
               2'd2:    mDout = mixPins(pbIn, mDrb, mDdrb);
               default: mDout = mDdrb;
            endcase
         end else if (addr[0]) begin
            mDout = {mTimerFlag, mPa7Flag, 6'b0};
         end else begin
            mDout = mCounter;
         end
      end
      // Accesses beat a same-edge event
      if (timerRead || timerWrite) mTimerFlag = 1'b0;
      else if (expireNow) mTimerFlag = 1'b1;
      if (flagRead) mPa7Flag = 1'b0;
      else if (edgeSeen) mPa7Flag = 1'b1;
      mPa7Prev = pa7Now;
      if (timerWrite) begin
         mCounter  = din;
         mDivSel   = addr[1:0];
         mPrescale = divReload(addr[1:0]);
         mTimerEn  = addr[3];
      end else if (mPrescale != 0) begin
         mPrescale--;
      end else begin
         if (mCounter == 8'h00) mDivSel = 2'd0;  // Expired so count every cycle
         mCounter  = mCounter - 8'd1;
         mPrescale = divReload(mDivSel);
      end
      if (sel && !rwN) begin
         if (!rsN) begin
            mRam[addr] = din;
         end else if (!addr[2]) begin
            case (addr[1:0])
               2'd0:    mDra  = din;
               2'd1:    mDdra = din;
               2'd2:    mDrb  = din;
               default: mDdrb = din;
            endcase
         end else if (!addr[4]) begin
            mEdgeMode = addr[0];
            mPa7En    = addr[1];
         end
      end
   endtask

   always @(posedge CLK) begin
      if (!rstN) modelReset();
      else modelStep();
   end

   task automatic step();
      @(posedge CLK);
      #1;  // Drive and sample clear of the edge
   endtask

   task automatic idleBus();
      cs  = 1'b0;
      csN = 1'b1;
      rwN = 1'b1;
   endtask

   // One bus cycle and back to idle
   task automatic access(input logic read, input logic rs, input ramAddrT a, input byteT d);
      cs   = 1'b1;
      csN  = 1'b0;
      rsN  = rs;
      rwN  = read;
      addr = a;
      din  = d;
      step();
      idleBus();
   endtask

   task automatic checkValue(input string what, input byteT exp, input byteT act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
      end
   endtask

   task automatic report(input string what);
      errors++;
      $display("error in %s: %s", testName, what);
   endtask

   task automatic checkPins();
      checkValue("paOut", mDra & mDdra, paOut);
      checkValue("pbOut", mDrb & mDdrb, pbOut);
      checkValue("irqN", {7'd0, expIrqN()}, {7'd0, irqN});
   endtask

   task automatic beginTest(input string name);
      testName      = name;
      errorsAtStart = errors;
   endtask

   task automatic endTest();
      testsRun++;
      if (errors == errorsAtStart) begin
         $display("test %s: ok", testName);
      end else begin
         testsFailed++;
         $display("test %s: %0d errors", testName, errors - errorsAtStart);
      end
   endtask

   task automatic testRam();
      ramAddrT used [$];
      ramAddrT a;
      beginTest("ram");
      for (int i = 0; i < 200; i++) begin
         a = ramAddrT'(nextRand());
         access(1'b0, 1'b0, a, byteT'(nextRand()));
         used.push_back(a);
      end
      foreach (used[i]) begin
         access(1'b1, 1'b0, used[i], 8'h00);
         checkValue("ram read", mDout, dout);
      end
      endTest();
   endtask

   task automatic testPorts();
      logic [31:0] r;
      beginTest("ports");
      for (int i = 0; i < 150; i++) begin
         r    = nextRand();
         paIn = byteT'(nextRand());
         pbIn = byteT'(nextRand());
         access(r[2], 1'b1, {5'd0, r[1:0]}, byteT'(nextRand()));  // addr[2] low selects ports
         checkPins();
         if (r[2]) checkValue("port read", mDout, dout);
      end
      endTest();
   endtask

   task automatic testTimerCount();
      int gap;
      beginTest("timer count");
      for (int t = 0; t < 6; t++) begin
         // Each divider in turn with small loads so most runs wrap
         access(1'b0, 1'b1, {3'b001, 2'b01, 2'(t)}, byteT'(nextRand() % 40));
         for (int k = 0; k < 12; k++) begin
            gap = nextRand() % 48;
            repeat (gap) step();
            access(1'b1, 1'b1, 7'h04, 8'h00);
            checkValue("timer read", mDout, dout);
         end
      end
      endTest();
   endtask

   task automatic testTimerIrq();
      int waited;
      beginTest("timer irq");
      access(1'b0, 1'b1, {3'b001, 2'b11, 2'(nextRand() % 2)}, 8'd1 + byteT'(nextRand() % 6));
      waited = 0;
      while (expIrqN() && waited < 200) begin
         step();
         waited++;
         checkPins();
      end
      if (expIrqN()) report("timer never expired within 200 cycles");
      checkValue("irqN at expiry", 8'h00, {7'd0, irqN});
      access(1'b1, 1'b1, 7'h05, 8'h00);  // Flag read keeps the timer flag
      checkValue("flag read", mDout, dout);
      checkValue("timer flag bit", 8'h01, {7'd0, dout[7]});
      access(1'b1, 1'b1, 7'h04, 8'h00);
      checkValue("irqN after timer read", 8'h01, {7'd0, irqN});
      checkPins();
      access(1'b0, 1'b1, 7'h14, 8'hFF);  // Interrupt off for later tests
      endTest();
   endtask

   task automatic testPa7Edge();
      logic mode;
      beginTest("pa7 edge");
      for (int m = 0; m < 2; m++) begin
         mode = m[0];
         access(1'b0, 1'b1, 7'h01, 8'h00);  // ddra 0 so PA7 follows the pin
         paIn[7] = ~mode;
         step();
         step();
         access(1'b0, 1'b1, {5'b00001, 1'b1, mode}, 8'h00);
         access(1'b1, 1'b1, 7'h05, 8'h00);  // Drop stale flag
         checkValue("irqN before edge", 8'h01, {7'd0, irqN});
         paIn[7] = mode;
         step();
         checkValue("irqN on selected edge", 8'h00, {7'd0, irqN});
         checkPins();
         access(1'b1, 1'b1, 7'h05, 8'h00);
         checkValue("flag read", mDout, dout);
         checkValue("edge flag bit", 8'h01, {7'd0, dout[6]});
         checkValue("irqN after flag read", 8'h01, {7'd0, irqN});
         paIn[7] = ~mode;  // Opposite edge sets no flag
         step();
         step();
         checkValue("irqN on other edge", 8'h01, {7'd0, irqN});
         access(1'b1, 1'b1, 7'h05, 8'h00);
         checkValue("edge flag bit clear", 8'h00, {7'd0, dout[6]});
      end
      access(1'b0, 1'b1, 7'h04, 8'h00);  // Edge interrupt off
      endTest();
   endtask

   initial begin
      rstN = 1'b0;
      cs   = 1'b0;
      csN  = 1'b1;
      rsN  = 1'b1;
      rwN  = 1'b1;
      addr = '0;
      din  = 8'h00;
      paIn = 8'h00;
      pbIn = 8'h00;
      repeat (16) @(posedge CLK);
      #1;
      rstN = 1'b1;
      beginTest("reset");
      checkValue("dout", 8'h00, dout);
      checkValue("irqN", 8'h01, {7'd0, irqN});
      checkValue("paOut", 8'h00, paOut);
      checkValue("pbOut", 8'h14, pbOut);
      endTest();
      testRam();
      testPorts();
      testTimerCount();
      testTimerIrq();
      testPa7Edge();
      if (UUT.boundChecks.failCount != 0) begin
         errors += UUT.boundChecks.failCount;
         $display("bound assertions failed %0d times", UUT.boundChecks.failCount);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: riotTop.f
source/riotPkg.sv
source/riotBusInterface.sv
source/riotRam.sv
source/riotPorts.sv
source/riotTimer.sv
source/riotTop.sv
dv/riotAssertions.sv
dv/riotTb.sv

// File: Bender.yml
package:
  name: riot

sources:
  # Design, package first
  - source/riotPkg.sv
  - source/riotBusInterface.sv
  - source/riotRam.sv
  - source/riotPorts.sv
  - source/riotTimer.sv
  - source/riotTop.sv

  # Verification only
  - target: simulation
    files:
      - dv/riotAssertions.sv
      - dv/riotTb.sv
